//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f sim.f --top-module cart_tb \
	-Mdir obj_dir -o cart_sim

out=$(./obj_dir/cart_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
	exit 0
else
	exit 1
fi

//--- sim.f
+incdir+src
src/cart_bus_pkg.sv
src/cart_map_pkg.sv
src/bus_cycle_capture.sv
src/mbc_mapper.sv
src/cart_memory.sv
src/cart_top.sv
sim/cart_tb.sv

//--- sim/cart_tb.sv
`timescale 1ns/1ps

module cart_tb;

	// Data value in the file that asks for a random byte.
	localparam int unsigned RANDOM_MARK = 32'h100;
	localparam int          RESET_CYCLES = 10;

	// DUT ports.
	logic                     clk;
	logic                     reset;
	logic                     default_mode;
	cart_bus_pkg::cpu_addr_t  addr;
	cart_bus_pkg::cpu_data_t  wdata;
	logic                     read;
	logic                     write;
	logic                     rom_sel;
	cart_map_pkg::phys_addr_t rom_addr;
	logic                     rd_valid;
	cart_bus_pkg::cpu_data_t  rd_data;

	// Test table, one entry per file line.
	byte         t_op[$];
	int unsigned t_addr[$];
	int unsigned t_data[$];
	int unsigned t_exp[$];

	// Random bytes written, oldest first.
	cart_bus_pkg::cpu_data_t rand_bytes[$];
	logic [31:0]             rng_state = 32'd13130;

	// Run length guard.
	int unsigned cycle_count = 0;
	int unsigned cycle_limit = 1000;

	cart_top uut (
		.clk          (clk),
		.reset        (reset),
		.default_mode (default_mode),
		.addr         (addr),
		.wdata        (wdata),
		.read         (read),
		.write        (write),
		.rom_sel      (rom_sel),
		.rom_addr     (rom_addr),
		.rd_valid     (rd_valid),
		.rd_data      (rd_data)
	);

	// 20 ns clock.
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Cycle counter against the limit.
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("timeout: run went past %0d cycles", cycle_limit);
			stop_on_failure();
		end
	end

	task automatic stop_on_failure();
		$display("TEST FAILED");
		$fatal(1, "run stopped at first error");
	endtask

	// 32-bit xorshift step.
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	task automatic check_phys(input cart_map_pkg::phys_addr_t got,
			input cart_map_pkg::phys_addr_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s rom_addr %06h, expected %06h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	task automatic check_byte(input cart_bus_pkg::cpu_data_t got,
			input cart_bus_pkg::cpu_data_t exp, input string what);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s rd_data %02h, expected %02h", $time, what, got, exp);
			stop_on_failure();
		end
	endtask

	// Output strobes present or absent as the access demands.
	task automatic expect_response(input logic want_rom, input logic want_rd, input string what);
		if (want_rom && rom_sel !== 1'b1) begin
			$display("no rom_sel pulse after %s", what);
			stop_on_failure();
		end
		if (!want_rom && rom_sel !== 1'b0) begin
			$display("unexpected rom_sel pulse after %s", what);
			stop_on_failure();
		end
		if (want_rd && rd_valid !== 1'b1) begin
			$display("no rd_valid pulse after %s", what);
			stop_on_failure();
		end
		if (!want_rd && rd_valid !== 1'b0) begin
			$display("unexpected rd_valid pulse after %s", what);
			stop_on_failure();
		end
	endtask

	// Fill the test table from the data file.
	task automatic load_tests();
		int          fd;
		int          n;
		string       line;
		string       op_s;
		int unsigned a;
		int unsigned d;
		int unsigned e;
		fd = $fopen("sim/cart_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open sim/cart_tests.txt");
			stop_on_failure();
		end
		while ($fgets(line, fd) != 0) begin
			// Comments and blank lines.
			if (line.len() == 0 || line[0] == "#" || line[0] == "\n") begin
				continue;
			end
			n = $sscanf(line, "%s %h %h %h", op_s, a, d, e);
			if (n != 4 || !(op_s == "R" || op_s == "A" || op_s == "W")) begin
				$display("bad line in test file: %s", line);
				stop_on_failure();
			end
			t_op.push_back(op_s[0]);
			t_addr.push_back(a);
			t_data.push_back(d);
			t_exp.push_back(e);
		end
		$fclose(fd);
		if (t_op.size() == 0) begin
			$display("test file holds no accesses");
			stop_on_failure();
		end
		// Four cycles per access, twice over for margin.
		cycle_limit = t_op.size() * 8 + RESET_CYCLES + 20;
	endtask

	// One strobe cycle, entered and left on a falling edge.
	task automatic run_access(input int idx);
		byte                      op;
		cart_bus_pkg::cpu_addr_t  a;
		cart_bus_pkg::cpu_data_t  d;
		cart_bus_pkg::cpu_data_t  exp_b;
		cart_map_pkg::phys_addr_t exp_p;
		string                    what;
		op    = t_op[idx];
		a     = t_addr[idx][15:0];
		d     = t_data[idx][7:0];
		exp_p = t_exp[idx][20:0];
		exp_b = t_exp[idx][7:0];
		if (op == "W" && t_data[idx] == RANDOM_MARK) begin
			rng_state = xorshift32(rng_state);
			d = rng_state[7:0];
			rand_bytes.push_back(d);
		end
		what = $sformatf("line %0d %s %04h", idx + 1, op == "W" ? "write" : "read", a);
		addr  = a;
		wdata = d;
		read  = (op != "W");
		write = (op == "W");
		// Strobe held over two sampled edges.
		@(posedge clk);
		@(negedge clk);
		@(posedge clk);
		@(negedge clk);
		read  = 1'b0;
		write = 1'b0;
		// Third edge registers the response.
		@(posedge clk);
		@(negedge clk);
		case (op)
			"R": begin
				expect_response(1'b1, 1'b0, what);
				check_phys(rom_addr, exp_p, what);
			end
			"A": begin
				if (t_exp[idx] == RANDOM_MARK) begin
					if (rand_bytes.size() == 0) begin
						$display("random read at %s with no random byte written", what);
						stop_on_failure();
					end
					exp_b = rand_bytes.pop_front();
				end
				expect_response(1'b0, 1'b1, what);
				check_byte(rd_data, exp_b, what);
			end
			default: begin
				// Writes answer nothing.
				expect_response(1'b0, 1'b0, what);
			end
		endcase
		// Strobe stays low for a second edge.
		@(posedge clk);
		@(negedge clk);
	endtask

	initial begin
		reset        = 1'b1;
		default_mode = 1'b0;
		addr         = '0;
		wdata        = '0;
		read         = 1'b0;
		write        = 1'b0;
		load_tests();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < t_op.size(); i++) begin
			run_access(i);
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule

//--- sim/cart_tests.txt
# op addr data expect; op R is a ROM read expecting rom_addr, A a RAM read expecting rd_data, W a write
# data 100 on W writes a random byte; expect 100 on A reads back the oldest random byte written
R 0000 00 000000
R 1234 00 001234
R 3fff 00 003fff
W 2000 00 0
R 4000 00 004000
W 2000 01 0
R 5000 00 005000
W 2000 05 0
R 4123 00 014123
W 2000 1f 0
R 7fff 00 07ffff
W 2000 00 0
W 4000 02 0
R 4000 00 104000
R 4567 00 104567
W 6000 01 0
W 4000 01 0
R 4000 00 104000
W 0000 0a 0
W 4000 00 0
W a000 55 0
A a000 00 55
W 0000 00 0
W a000 77 0
A a000 00 55
W 0000 0a 0
W a000 66 0
A a000 00 66
W 4000 01 0
W a010 11 0
W 4000 02 0
W a010 22 0
W 4000 01 0
A a010 00 11
W 4000 02 0
A a010 00 22
W 4000 00 0
W b000 100 0
W 4000 01 0
W b000 100 0
W 4000 02 0
W b000 100 0
W 4000 03 0
W b000 100 0
W 4000 00 0
A b000 00 100
W 4000 01 0
A b000 00 100
W 4000 02 0
A b000 00 100
W 4000 03 0
A b000 00 100

//--- src/bus_cycle_capture.sv
`timescale 1ns/1ps

module bus_cycle_capture (
	input  logic                    clk,
	input  logic                    reset,
	input  cart_bus_pkg::cpu_addr_t addr,
	input  cart_bus_pkg::cpu_data_t wdata,
	input  logic                    read,
	input  logic                    write,
	output logic                    acc_valid,
	output logic                    acc_write,
	output cart_bus_pkg::cpu_addr_t acc_addr,
	output cart_bus_pkg::cpu_data_t acc_data
);

	// Waiting for a strobe, or waiting for it to drop.
	typedef enum logic {
		cap_idle,
		cap_held
	} cap_state_t;

	cap_state_t state;
	logic       one_strobe;
	logic       any_strobe;

	// Exactly one of read/write high.
	assign one_strobe = read ^ write;
	assign any_strobe = read | write;

	// Strobe FSM and access pulse.
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= cap_idle;
			acc_valid <= 1'b0;
		end else begin
			// Pulse lasts one cycle only.
			acc_valid <= 1'b0;
			case (state)
				cap_idle: begin
					// Both strobes high still parks in held, but with no pulse.
					if (any_strobe) begin
						state     <= cap_held;
						acc_valid <= one_strobe;
					end
				end
				cap_held: begin
					// Re-arm once the bus is quiet.
					if (!any_strobe) begin
						state <= cap_idle;
					end
				end
				default: begin
					state <= cap_idle;
				end
			endcase
		end
	end

	// Access fields, latched with the pulse.
	always_ff @(posedge clk) begin
		if (state == cap_idle && one_strobe) begin
			acc_addr  <= addr;
			acc_data  <= wdata;
			acc_write <= write;
		end
	end

	// One pulse per strobe assertion.
	a_single_pulse: assert property (
		@(posedge clk) disable iff (reset)
		acc_valid |=> !acc_valid
	);

endmodule

//--- src/cart_bus_pkg.sv
package cart_bus_pkg;

	// CPU side of the cartridge slot.

	// Address as driven by the console CPU.
	typedef logic [15:0] cpu_addr_t;

	// One data byte on the cartridge bus.
	typedef logic [7:0] cpu_data_t;

endpackage

//--- src/cart_defs.svh
`ifndef CART_DEFS_SVH
`define CART_DEFS_SVH

// Number of 8 KiB RAM banks fitted on the cartridge.
`define CART_RAM_BANKS 4

// Low nibble that opens RAM for writes.
`define CART_RAM_ENABLE_KEY 4'hA

// Offset width inside one RAM bank.
`define CART_RAM_BANK_OFFSET_W 13
// Offset width inside one ROM bank.
`define CART_ROM_BANK_OFFSET_W 14

// Windows decoded on A15..A13.
// 0x0000-0x1FFF, RAM enable.
`define CART_WIN_RAM_ENABLE 3'b000
// 0x2000-0x3FFF, ROM bank bits 0-4.
`define CART_WIN_ROM_BANK_LO 3'b001
// 0x4000-0x5FFF, ROM bits 5-6 or RAM bank.
`define CART_WIN_BANK_HI 3'b010
// 0x6000-0x7FFF, banking mode.
`define CART_WIN_MODE 3'b011
// 0xA000-0xBFFF, cartridge RAM.
`define CART_WIN_CART_RAM 3'b101

`endif

//--- src/cart_map_pkg.sv
package cart_map_pkg;

	// Physical side of the bank controller.

	// Bank number in the upper bits, offset below.
	typedef logic [20:0] phys_addr_t;

	// Full 7-bit ROM bank, bits 5-6 shared with RAM bank.
	typedef logic [6:0] rom_bank_t;

	// RAM bank as held by the controller.
	typedef logic [3:0] ram_bank_t;

	// What the 0x4000-0x5FFF register drives.
	typedef enum logic {
		// Upper ROM bank bits.
		mode_rom_banking = 1'b0,
		// RAM bank select.
		mode_ram_banking = 1'b1
	} bank_mode_t;

endpackage

//--- src/cart_memory.sv
`timescale 1ns/1ps
`include "cart_defs.svh"

module cart_memory (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     sel_rom,
	input  logic                     sel_ram,
	input  logic                     sel_write,
	input  cart_map_pkg::phys_addr_t phys_addr,
	input  cart_bus_pkg::cpu_data_t  sel_data,
	output logic                     rom_sel,
	output cart_map_pkg::phys_addr_t rom_addr,
	output logic                     rd_valid,
	output cart_bus_pkg::cpu_data_t  rd_data
);

	// Bank index bits actually fitted.
	localparam int RAM_BANK_W = $clog2(`CART_RAM_BANKS);
	// Full RAM word index.
	localparam int RAM_IDX_W  = RAM_BANK_W + `CART_RAM_BANK_OFFSET_W;
	localparam int RAM_WORDS  = `CART_RAM_BANKS << `CART_RAM_BANK_OFFSET_W;

	// Battery-backed RAM, kept across reset.
	cart_bus_pkg::cpu_data_t ram [0:RAM_WORDS-1];

	logic [RAM_IDX_W-1:0] ram_idx;
	logic                 ram_wr;
	logic                 ram_rd;

	// Low bank bits wrap onto the fitted banks.
	assign ram_idx = {
		phys_addr[`CART_RAM_BANK_OFFSET_W +: RAM_BANK_W],
		phys_addr[`CART_RAM_BANK_OFFSET_W-1:0]
	};

	assign ram_wr = sel_ram && sel_write;
	assign ram_rd = sel_ram && !sel_write;

	// RAM array port.
	always_ff @(posedge clk) begin
		if (ram_wr) begin
			ram[ram_idx] <= sel_data;
		end
		if (ram_rd) begin
			rd_data <= ram[ram_idx];
		end
	end

	// ROM pins follow the physical address.
	always_ff @(posedge clk) begin
		if (sel_rom) begin
			rom_addr <= phys_addr;
		end
	end

	// Strobes towards the outside.
	always_ff @(posedge clk) begin
		if (reset) begin
			rom_sel  <= 1'b0;
			rd_valid <= 1'b0;
		end else begin
			rom_sel  <= sel_rom;
			// Writes produce no response.
			rd_valid <= ram_rd;
		end
	end

	// ROM and RAM never answer in the same cycle.
	a_out_onehot: assert property (
		@(posedge clk) disable iff (reset)
		!(rd_valid && rom_sel)
	);

endmodule

//--- src/cart_top.sv
`timescale 1ns/1ps

module cart_top (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     default_mode,
	input  cart_bus_pkg::cpu_addr_t  addr,
	input  cart_bus_pkg::cpu_data_t  wdata,
	input  logic                     read,
	input  logic                     write,
	output logic                     rom_sel,
	output cart_map_pkg::phys_addr_t rom_addr,
	output logic                     rd_valid,
	output cart_bus_pkg::cpu_data_t  rd_data
);

	// Capture to mapper.
	logic                     acc_valid;
	logic                     acc_write;
	cart_bus_pkg::cpu_addr_t  acc_addr;
	cart_bus_pkg::cpu_data_t  acc_data;

	// Mapper to memory.
	logic                     sel_rom;
	logic                     sel_ram;
	logic                     sel_write;
	cart_map_pkg::phys_addr_t phys_addr;
	cart_bus_pkg::cpu_data_t  sel_data;

	// Strobe levels to access pulses.
	bus_cycle_capture u_capture (
		.clk       (clk),
		.reset     (reset),
		.addr      (addr),
		.wdata     (wdata),
		.read      (read),
		.write     (write),
		.acc_valid (acc_valid),
		.acc_write (acc_write),
		.acc_addr  (acc_addr),
		.acc_data  (acc_data)
	);

	// Bank registers and translation.
	mbc_mapper u_mapper (
		.clk          (clk),
		.reset        (reset),
		.default_mode (default_mode),
		.acc_valid    (acc_valid),
		.acc_write    (acc_write),
		.acc_addr     (acc_addr),
		.acc_data     (acc_data),
		.sel_rom      (sel_rom),
		.sel_ram      (sel_ram),
		.sel_write    (sel_write),
		.phys_addr    (phys_addr),
		.sel_data     (sel_data)
	);

	// Cartridge RAM and ROM pins.
	cart_memory u_memory (
		.clk       (clk),
		.reset     (reset),
		.sel_rom   (sel_rom),
		.sel_ram   (sel_ram),
		.sel_write (sel_write),
		.phys_addr (phys_addr),
		.sel_data  (sel_data),
		.rom_sel   (rom_sel),
		.rom_addr  (rom_addr),
		.rd_valid  (rd_valid),
		.rd_data   (rd_data)
	);

endmodule

//--- src/mbc_mapper.sv
`timescale 1ns/1ps
`include "cart_defs.svh"

module mbc_mapper (
	input  logic                     clk,
	input  logic                     reset,
	input  logic                     default_mode,
	input  logic                     acc_valid,
	input  logic                     acc_write,
	input  cart_bus_pkg::cpu_addr_t  acc_addr,
	input  cart_bus_pkg::cpu_data_t  acc_data,
	output logic                     sel_rom,
	output logic                     sel_ram,
	output logic                     sel_write,
	output cart_map_pkg::phys_addr_t phys_addr,
	output cart_bus_pkg::cpu_data_t  sel_data
);

	// Bank controller state.
	cart_map_pkg::rom_bank_t  rom_bank;
	cart_map_pkg::ram_bank_t  ram_bank;
	cart_map_pkg::bank_mode_t mode;
	logic                     ram_wr_en;

	// Decode and translation.
	cart_map_pkg::rom_bank_t  rom_bank_eff;
	cart_map_pkg::phys_addr_t xlat_addr;
	logic [2:0]               win;
	logic                     in_rom_space;
	logic                     in_ram_space;

	// Window on A15..A13.
	assign win          = acc_addr[15:13];
	// 0x0000-0x7FFF.
	assign in_rom_space = ~acc_addr[15];
	assign in_ram_space = (win == `CART_WIN_CART_RAM);

	// Banks 0x00, 0x20, 0x40, 0x60 step up by one.
	assign rom_bank_eff = {rom_bank[6:1], rom_bank[0] | ~|rom_bank[4:0]};

	// Address translation.
	always_comb begin
		// Bank 0 and unmapped space pass straight through.
		xlat_addr = {5'b0, acc_addr};
		if (in_rom_space && acc_addr[14]) begin
			// Switchable ROM bank.
			xlat_addr = {rom_bank_eff, acc_addr[`CART_ROM_BANK_OFFSET_W-1:0]};
		end else if (in_ram_space) begin
			// Switchable RAM bank.
			xlat_addr = {4'b0, ram_bank, acc_addr[`CART_RAM_BANK_OFFSET_W-1:0]};
		end
	end

	// Control registers and selects.
	always_ff @(posedge clk) begin
		if (reset) begin
			rom_bank  <= '0;
			ram_bank  <= '0;
			ram_wr_en <= 1'b0;
			mode      <= cart_map_pkg::bank_mode_t'(default_mode);
			sel_rom   <= 1'b0;
			sel_ram   <= 1'b0;
		end else begin
			// ROM side is read only.
			sel_rom <= acc_valid && !acc_write && in_rom_space;
			// RAM writes only while enabled.
			sel_ram <= acc_valid && in_ram_space && (!acc_write || ram_wr_en);

			// Register writes land in ROM space.
			if (acc_valid && acc_write) begin
				case (win)
					`CART_WIN_RAM_ENABLE: begin
						// Any other value closes RAM.
						ram_wr_en <= (acc_data[3:0] == `CART_RAM_ENABLE_KEY);
					end
					`CART_WIN_ROM_BANK_LO: begin
						rom_bank[4:0] <= acc_data[4:0];
					end
					`CART_WIN_BANK_HI: begin
						// Same register, two uses.
						if (mode == cart_map_pkg::mode_rom_banking) begin
							rom_bank[6:5] <= acc_data[1:0];
						end else begin
							ram_bank <= acc_data[3:0];
						end
					end
					`CART_WIN_MODE: begin
						mode <= cart_map_pkg::bank_mode_t'(acc_data[0]);
					end
					default: begin
						// RAM space and unmapped writes change nothing.
					end
				endcase
			end
		end
	end

	// Access payload for the memory stage.
	always_ff @(posedge clk) begin
		if (acc_valid) begin
			sel_write <= acc_write;
			phys_addr <= xlat_addr;
			sel_data  <= acc_data;
		end
	end

	// ROM and RAM selects are exclusive.
	a_sel_onehot: assert property (
		@(posedge clk) disable iff (reset)
		!(sel_rom && sel_ram)
	);

	// RAM write only while the enable register stays set.
	a_ram_wr_gated: assert property (
		@(posedge clk) disable iff (reset)
		(sel_ram && sel_write) |-> ram_wr_en
	);

endmodule
